// File: arch_reg_pkg.sv
// Sizes of the architectural integer register file.
// Referenced by scoped name from the rename stage modules.

`default_nettype none

package arch_reg_pkg;

  // Integer registers visible to software
  localparam int ARF_SIZE = 8;

  // Bits needed to name one architectural register
  localparam int ARF_INDEX_SIZE = $clog2(ARF_SIZE);

endpackage

`default_nettype wire

// File: free_list.sv
// Free list of physical registers for the rename stage.
// A ring with a speculative head for renames, a committed head for retirement
// and a tail for freed registers. Recover rolls the speculative head back.

`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  logic clock,
  input  logic reset,
  input  logic recover,
  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0] prf_req,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0] retire_valid,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0] pre_prf_valid,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] pre_prf,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prf_out,
  output logic allocatable
);

  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] ring [phys_reg_pkg::PRF_SIZE];

  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] spec_head;
  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] commit_head;
  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] tail;
  logic [phys_reg_pkg::FREE_COUNT_SIZE-1:0] free_count;

  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] commit_head_next;
  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] tail_next;

  // Ring slot read by each rename lane, written by each commit lane
  logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] alloc_ptr;
  logic [phys_reg_pkg::COMMIT_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] release_ptr;

  logic [phys_reg_pkg::FREE_COUNT_SIZE-1:0] alloc_num;
  logic [phys_reg_pkg::FREE_COUNT_SIZE-1:0] retire_num;
  logic [phys_reg_pkg::FREE_COUNT_SIZE-1:0] release_num;

  assign allocatable = (free_count >= phys_reg_pkg::RENAME_WIDTH);

  // Requesting lanes take consecutive entries in lane order
  always_comb begin
    alloc_num = '0;
    for (int i = 0; i < phys_reg_pkg::RENAME_WIDTH; i++) begin
      alloc_ptr[i] = spec_head + alloc_num[phys_reg_pkg::PRF_INDEX_SIZE-1:0];
      prf_out[i]   = ring[alloc_ptr[i]];
      if (prf_req[i]) begin
        alloc_num = alloc_num + 1'b1;
      end
    end
    if (!allocatable) begin
      alloc_num = '0;
    end
  end

  always_comb begin
    retire_num  = '0;
    release_num = '0;
    for (int i = 0; i < phys_reg_pkg::COMMIT_WIDTH; i++) begin
      release_ptr[i] = tail + release_num[phys_reg_pkg::PRF_INDEX_SIZE-1:0];
      if (pre_prf_valid[i]) begin
        release_num = release_num + 1'b1;
      end
      if (retire_valid[i]) begin
        retire_num = retire_num + 1'b1;
      end
    end
    commit_head_next = commit_head + retire_num[phys_reg_pkg::PRF_INDEX_SIZE-1:0];
    tail_next        = tail + release_num[phys_reg_pkg::PRF_INDEX_SIZE-1:0];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Physical 0 stays mapped, 1 to 15 start free
      for (int i = 0; i < phys_reg_pkg::PRF_SIZE; i++) begin
        ring[i] <= i[phys_reg_pkg::PRF_INDEX_SIZE-1:0] + 1'b1;
      end
      spec_head   <= '0;
      commit_head <= '0;
      tail        <= '1;
      free_count  <= {1'b0, {phys_reg_pkg::PRF_INDEX_SIZE{1'b1}}};
    end else begin
      for (int i = 0; i < phys_reg_pkg::COMMIT_WIDTH; i++) begin
        if (pre_prf_valid[i]) begin
          ring[release_ptr[i]] <= pre_prf[i];
        end
      end
      commit_head <= commit_head_next;
      tail        <= tail_next;
      if (recover) begin
        // Everything between the committed head and the tail is free again
        spec_head  <= commit_head_next;
        free_count <= {1'b0, tail_next - commit_head_next};
      end else begin
        spec_head  <= spec_head + alloc_num[phys_reg_pkg::PRF_INDEX_SIZE-1:0];
        free_count <= free_count - alloc_num + release_num;
      end
    end
  end

endmodule

`default_nettype wire

// File: mapping_table.sv
// Speculative and retired register alias tables of the rename stage.
// Renames a group in lane order so later lanes see earlier destinations,
// and tracks retirement so a recover can restore the committed map.

`timescale 1ns/1ps
`default_nettype none

module mapping_table (
  input  logic clock,
  input  logic reset,
  input  logic recover,

  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0] rd_valid,
  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] rs1,
  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] rs2,
  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] rd,

  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0] retire_valid,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] retire_prf,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] retire_arf,

  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prf_out,
  input  logic allocatable,

  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prs1,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prs2,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prd,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prev_rd,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0] prev_rd_valid
);

  // Speculative map, updated by renames
  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] spec_map      [arch_reg_pkg::ARF_SIZE];
  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] spec_map_next [arch_reg_pkg::ARF_SIZE];
  logic [arch_reg_pkg::ARF_SIZE-1:0]       spec_valid;
  logic [arch_reg_pkg::ARF_SIZE-1:0]       spec_valid_next;

  // Retired map, updated by commits
  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] ret_map       [arch_reg_pkg::ARF_SIZE];
  logic [phys_reg_pkg::PRF_INDEX_SIZE-1:0] ret_map_next  [arch_reg_pkg::ARF_SIZE];
  logic [arch_reg_pkg::ARF_SIZE-1:0]       ret_valid;
  logic [arch_reg_pkg::ARF_SIZE-1:0]       ret_valid_next;

  always_comb begin
    ret_map_next   = ret_map;
    ret_valid_next = ret_valid;
    for (int i = 0; i < phys_reg_pkg::COMMIT_WIDTH; i++) begin
      if (retire_valid[i]) begin
        ret_map_next[retire_arf[i]]   = retire_prf[i];
        ret_valid_next[retire_arf[i]] = 1'b1;
      end
    end
  end

  // Walk the group in lane order, reading the map as updated so far
  always_comb begin
    spec_map_next   = spec_map;
    spec_valid_next = spec_valid;
    prs1            = '0;
    prs2            = '0;
    prd             = '0;
    prev_rd         = '0;
    prev_rd_valid   = '0;
    if (allocatable) begin
      for (int i = 0; i < phys_reg_pkg::RENAME_WIDTH; i++) begin
        if (rs1[i] != '0) begin
          prs1[i] = spec_map_next[rs1[i]];
        end
        if (rs2[i] != '0) begin
          prs2[i] = spec_map_next[rs2[i]];
        end
        if (rd_valid[i]) begin
          // Old mapping goes to commit so it can be freed there
          prev_rd[i]            = spec_map_next[rd[i]];
          prev_rd_valid[i]      = spec_valid_next[rd[i]];
          prd[i]                = prf_out[i];
          spec_map_next[rd[i]]  = prf_out[i];
          spec_valid_next[rd[i]] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arch_reg_pkg::ARF_SIZE; i++) begin
        spec_map[i] <= '0;
        ret_map[i]  <= '0;
      end
      spec_valid <= {{(arch_reg_pkg::ARF_SIZE-1){1'b0}}, 1'b1};
      ret_valid  <= {{(arch_reg_pkg::ARF_SIZE-1){1'b0}}, 1'b1};
    end else begin
      ret_map   <= ret_map_next;
      ret_valid <= ret_valid_next;
      if (recover) begin
        // Same-cycle retirements are included, renames are dropped
        spec_map   <= ret_map_next;
        spec_valid <= ret_valid_next;
      end else begin
        spec_map   <= spec_map_next;
        spec_valid <= spec_valid_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: phys_reg_pkg.sv
// Physical register file sizes and the per-cycle widths of the rename stage.
// Referenced by scoped name from the free list, the map and the top level.

`default_nettype none

package phys_reg_pkg;

  // Physical registers behind the rename map
  localparam int PRF_SIZE = 16;
  localparam int PRF_INDEX_SIZE = $clog2(PRF_SIZE);

  // Instructions renamed and committed per cycle
  localparam int RENAME_WIDTH = 2;
  localparam int COMMIT_WIDTH = 2;

  // Free count must hold PRF_SIZE itself
  localparam int FREE_COUNT_SIZE = $clog2(PRF_SIZE + 1);

endpackage

`default_nettype wire

// File: rename_unit.f
arch_reg_pkg.sv
phys_reg_pkg.sv
free_list.sv
mapping_table.sv
rename_unit.sv
tb_clock_gen.sv
rename_unit_tb.sv

// File: rename_unit.sv
// Register rename stage of the integer core.
// Connects the alias tables to the free list. allocatable is the stage's
// own stall, and the front end holds its group while it is low.

`timescale 1ns/1ps
`default_nettype none

module rename_unit (
  input  logic clock,
  input  logic reset,
  input  logic recover,

  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0] rd_valid,
  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] rs1,
  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] rs2,
  input  logic [phys_reg_pkg::RENAME_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] rd,

  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0] pre_prf_valid,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] pre_prf,

  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0] retire_valid,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] retire_prf,
  input  logic [phys_reg_pkg::COMMIT_WIDTH-1:0][arch_reg_pkg::ARF_INDEX_SIZE-1:0] retire_arf,

  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prs1,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prs2,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prd,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prev_rd,
  output logic [phys_reg_pkg::RENAME_WIDTH-1:0] prev_rd_valid,
  output logic allocatable
);

  // Next free register for each lane, packed in lane order
  logic [phys_reg_pkg::RENAME_WIDTH-1:0][phys_reg_pkg::PRF_INDEX_SIZE-1:0] prf_out;

  mapping_table u_mapping_table (
    .clock         (clock),
    .reset         (reset),
    .recover       (recover),
    .rd_valid      (rd_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .retire_valid  (retire_valid),
    .retire_prf    (retire_prf),
    .retire_arf    (retire_arf),
    .prf_out       (prf_out),
    .allocatable   (allocatable),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .prev_rd_valid (prev_rd_valid)
  );

  free_list u_free_list (
    .clock         (clock),
    .reset         (reset),
    .recover       (recover),
    .prf_req       (rd_valid),
    .retire_valid  (retire_valid),
    .pre_prf_valid (pre_prf_valid),
    .pre_prf       (pre_prf),
    .prf_out       (prf_out),
    .allocatable   (allocatable)
  );

endmodule

`default_nettype wire

// File: rename_unit_tb.sv
// Table-driven testbench for the register rename stage.
// Each row drives one cycle of rename and commit inputs and holds the
// rename outputs expected in that cycle. Rows are grouped into tests.

`timescale 1ns/1ps
`default_nettype none

module rename_unit_tb;

  localparam int RW = phys_reg_pkg::RENAME_WIDTH;
  localparam int CW = phys_reg_pkg::COMMIT_WIDTH;
  localparam int AW = arch_reg_pkg::ARF_INDEX_SIZE;
  localparam int PW = phys_reg_pkg::PRF_INDEX_SIZE;
  localparam int CLOCK_PERIOD = 100;
  localparam int MAX_ROWS = 32;

  logic clock;
  logic reset;
  logic recover;
  logic [RW-1:0] rd_valid;
  logic [RW-1:0][AW-1:0] rs1;
  logic [RW-1:0][AW-1:0] rs2;
  logic [RW-1:0][AW-1:0] rd;
  logic [CW-1:0] pre_prf_valid;
  logic [CW-1:0][PW-1:0] pre_prf;
  logic [CW-1:0] retire_valid;
  logic [CW-1:0][PW-1:0] retire_prf;
  logic [CW-1:0][AW-1:0] retire_arf;
  logic [RW-1:0][PW-1:0] prs1;
  logic [RW-1:0][PW-1:0] prs2;
  logic [RW-1:0][PW-1:0] prd;
  logic [RW-1:0][PW-1:0] prev_rd;
  logic [RW-1:0] prev_rd_valid;
  logic allocatable;

  // Stimulus and expected values, one entry per cycle
  int                    row_test          [MAX_ROWS];
  logic [RW-1:0]         row_rd_valid      [MAX_ROWS];
  logic [RW-1:0][AW-1:0] row_rs1           [MAX_ROWS];
  logic [RW-1:0][AW-1:0] row_rs2           [MAX_ROWS];
  logic [RW-1:0][AW-1:0] row_rd            [MAX_ROWS];
  logic [CW-1:0]         row_pre_valid     [MAX_ROWS];
  logic [CW-1:0][PW-1:0] row_pre_prf       [MAX_ROWS];
  logic [CW-1:0]         row_retire_valid  [MAX_ROWS];
  logic [CW-1:0][PW-1:0] row_retire_prf    [MAX_ROWS];
  logic [CW-1:0][AW-1:0] row_retire_arf    [MAX_ROWS];
  logic                  row_recover       [MAX_ROWS];
  logic [RW-1:0][PW-1:0] row_prs1          [MAX_ROWS];
  logic [RW-1:0][PW-1:0] row_prs2          [MAX_ROWS];
  logic [RW-1:0][PW-1:0] row_prd           [MAX_ROWS];
  logic [RW-1:0][PW-1:0] row_prev_rd       [MAX_ROWS];
  logic [RW-1:0]         row_prev_valid    [MAX_ROWS];
  logic                  row_allocatable   [MAX_ROWS];

  int num_rows = 0;
  int check_count = 0;
  int error_count = 0;

  tb_clock_gen u_clock_gen (.clock(clock));

  rename_unit u_rename_unit (
    .clock         (clock),
    .reset         (reset),
    .recover       (recover),
    .rd_valid      (rd_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .pre_prf_valid (pre_prf_valid),
    .pre_prf       (pre_prf),
    .retire_valid  (retire_valid),
    .retire_prf    (retire_prf),
    .retire_arf    (retire_arf),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .prev_rd_valid (prev_rd_valid),
    .allocatable   (allocatable)
  );

  // Two architectural indices given as hex nibbles, lane 1 high
  function automatic logic [2*AW-1:0] arch_pair(input logic [7:0] nibbles);
    return {nibbles[4 +: AW], nibbles[0 +: AW]};
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "reset state";
      2: return "forwarding inside a group";
      3: return "write after write";
      4: return "exhaustion";
      5: return "commit and refill";
      default: return "recover";
    endcase
  endfunction

  task automatic add_row(input int t, input logic [RW-1:0] v, input logic [7:0] s1,
                         input logic [7:0] s2, input logic [7:0] d, input logic [7:0] e_prs1,
                         input logic [7:0] e_prs2, input logic [7:0] e_prd,
                         input logic [7:0] e_prev, input logic [RW-1:0] e_prev_valid,
                         input logic e_alloc);
    row_test[num_rows]         = t;
    row_rd_valid[num_rows]     = v;
    row_rs1[num_rows]          = arch_pair(s1);
    row_rs2[num_rows]          = arch_pair(s2);
    row_rd[num_rows]           = arch_pair(d);
    row_pre_valid[num_rows]    = '0;
    row_pre_prf[num_rows]      = '0;
    row_retire_valid[num_rows] = '0;
    row_retire_prf[num_rows]   = '0;
    row_retire_arf[num_rows]   = '0;
    row_recover[num_rows]      = 1'b0;
    row_prs1[num_rows]         = e_prs1;
    row_prs2[num_rows]         = e_prs2;
    row_prd[num_rows]          = e_prd;
    row_prev_rd[num_rows]      = e_prev;
    row_prev_valid[num_rows]   = e_prev_valid;
    row_allocatable[num_rows]  = e_alloc;
    num_rows++;
  endtask

  // Commit side of the row added last
  task automatic add_commit(input logic [CW-1:0] pv, input logic [7:0] pp,
                            input logic [CW-1:0] rv, input logic [7:0] rp,
                            input logic [7:0] ra, input logic rec);
    row_pre_valid[num_rows-1]    = pv;
    row_pre_prf[num_rows-1]      = pp;
    row_retire_valid[num_rows-1] = rv;
    row_retire_prf[num_rows-1]   = rp;
    row_retire_arf[num_rows-1]   = arch_pair(ra);
    row_recover[num_rows-1]      = rec;
  endtask

  // Row columns are test, rd_valid, rs1, rs2, rd and then the expected prs1, prs2,
  // prd, prev_rd, prev_rd_valid and allocatable. Pairs are hex, lane 1 high
  task automatic fill_table();
    add_row(1, 2'b11, 8'h31, 8'h42, 8'h21, 8'h00, 8'h00, 8'h21, 8'h00, 2'b00, 1'b1);
    add_row(2, 2'b11, 8'h31, 8'h00, 8'h33, 8'h31, 8'h00, 8'h43, 8'h30, 2'b10, 1'b1);
    add_row(2, 2'b00, 8'h03, 8'h20, 8'h00, 8'h04, 8'h20, 8'h00, 8'h00, 2'b00, 1'b1);
    add_row(3, 2'b01, 8'h21, 8'h32, 8'h01, 8'h21, 8'h42, 8'h05, 8'h01, 2'b01, 1'b1);
    add_row(3, 2'b10, 8'h11, 8'h00, 8'h20, 8'h55, 8'h00, 8'h60, 8'h20, 2'b10, 1'b1);
    add_row(4, 2'b11, 8'h44, 8'h50, 8'h54, 8'h70, 8'h00, 8'h87, 8'h00, 2'b00, 1'b1);
    add_row(4, 2'b11, 8'h65, 8'h00, 8'h76, 8'h98, 8'h00, 8'hA9, 8'h00, 2'b00, 1'b1);
    add_row(4, 2'b11, 8'h17, 8'h00, 8'h21, 8'hBA, 8'h00, 8'hCB, 8'h65, 2'b11, 1'b1);
    add_row(4, 2'b11, 8'h32, 8'h00, 8'h43, 8'hDC, 8'h00, 8'hED, 8'h74, 2'b11, 1'b1);
    // One entry left, the group is held
    add_row(4, 2'b11, 8'h21, 8'h43, 8'h65, 8'h00, 8'h00, 8'h00, 8'h00, 2'b00, 1'b0);
    add_commit(2'b00, 8'h00, 2'b11, 8'h21, 8'h21, 1'b0);
    add_row(5, 2'b11, 8'h21, 8'h43, 8'h65, 8'h00, 8'h00, 8'h00, 8'h00, 2'b00, 1'b0);
    add_commit(2'b10, 8'h30, 2'b11, 8'h43, 8'h33, 1'b0);
    add_row(5, 2'b11, 8'h21, 8'h43, 8'h65, 8'hCB, 8'hED, 8'h3F, 8'h98, 2'b11, 1'b1);
    add_commit(2'b11, 8'h21, 2'b11, 8'h65, 8'h21, 1'b0);
    add_row(5, 2'b11, 8'h65, 8'h00, 8'h17, 8'h3F, 8'h00, 8'h21, 8'hBA, 2'b11, 1'b1);
    add_row(6, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 2'b00, 1'b0);
    add_commit(2'b00, 8'h00, 2'b11, 8'h87, 8'h54, 1'b0);
    // Last retirement lands in the recover cycle
    add_row(6, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 2'b00, 1'b0);
    add_commit(2'b00, 8'h00, 2'b01, 8'h09, 8'h06, 1'b1);
    add_row(6, 2'b11, 8'h16, 8'h45, 8'h37, 8'h59, 8'h78, 8'hBA, 8'h40, 2'b10, 1'b1);
    add_row(6, 2'b11, 8'h27, 8'h03, 8'h52, 8'hCA, 8'h0B, 8'hDC, 8'h86, 2'b11, 1'b1);
    add_row(6, 2'b11, 8'h00, 8'h00, 8'h46, 8'h00, 8'h00, 8'hFE, 8'h79, 2'b11, 1'b1);
    add_row(6, 2'b01, 8'h61, 8'h00, 8'h01, 8'hE5, 8'h00, 8'h03, 8'h05, 2'b01, 1'b1);
    add_row(6, 2'b11, 8'h00, 8'h00, 8'h32, 8'h00, 8'h00, 8'h21, 8'hBC, 2'b11, 1'b1);
    add_row(6, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 2'b00, 1'b0);
  endtask

  task automatic apply_row(input int r);
    rd_valid      = row_rd_valid[r];
    rs1           = row_rs1[r];
    rs2           = row_rs2[r];
    rd            = row_rd[r];
    pre_prf_valid = row_pre_valid[r];
    pre_prf       = row_pre_prf[r];
    retire_valid  = row_retire_valid[r];
    retire_prf    = row_retire_prf[r];
    retire_arf    = row_retire_arf[r];
    recover       = row_recover[r];
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_row(input int r);
    check_value("prs1", 32'(prs1), 32'(row_prs1[r]));
    check_value("prs2", 32'(prs2), 32'(row_prs2[r]));
    check_value("prd", 32'(prd), 32'(row_prd[r]));
    check_value("prev_rd", 32'(prev_rd), 32'(row_prev_rd[r]));
    check_value("prev_rd_valid", 32'(prev_rd_valid), 32'(row_prev_valid[r]));
    check_value("allocatable", 32'(allocatable), 32'(row_allocatable[r]));
  endtask

  initial begin : watchdog
    wait (num_rows > 0);
    #((num_rows + 20) * CLOCK_PERIOD);
    $display("Run timed out before the stimulus table finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main_sequence
    int test_errors;
    $timeformat(-9, 0, " ns", 0);
    reset         = 1'b1;
    recover       = 1'b0;
    rd_valid      = '0;
    rs1           = '0;
    rs2           = '0;
    rd            = '0;
    pre_prf_valid = '0;
    pre_prf       = '0;
    retire_valid  = '0;
    retire_prf    = '0;
    retire_arf    = '0;
    test_errors   = 0;
    fill_table();
    repeat (10) @(posedge clock);
    for (int r = 0; r < num_rows; r++) begin
      #10;
      reset = 1'b0;
      apply_row(r);
      // Sample just before the next rising edge
      #(CLOCK_PERIOD - 20);
      compare_row(r);
      if (r == num_rows - 1 || row_test[r + 1] != row_test[r]) begin
        $display("Test %0d (%s) done with %0d errors", row_test[r],
                 test_name(row_test[r]), error_count - test_errors);
        test_errors = error_count;
      end
      @(posedge clock);
    end
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the rename stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rename_unit_tb -f rename_unit.f

./obj_dir/Vrename_unit_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"

// File: tb_clock_gen.sv
// Free-running clock for the rename stage testbench.
// Period is 100 ns, starting low at time zero.

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

endmodule

`default_nettype wire
